//--- src.f
conv_pkg.sv
axil_coef_port.sv
window_buffer.sv
conv_unit.sv
conv_layer_top.sv
tb_clock_gen.sv
conv_layer_checker.sv
conv_layer_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= conv_layer_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "sim passed" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- conv_layer_tb.sv
module conv_layer_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int num_images = 4;
	localparam int wait_limit = 50; // cycles per handshake wait

	logic                                           clk;
	logic                                           rst_n;
	logic                                           awvalid;
	logic                                           awready;
	logic [conv_pkg::axi_addr_w-1:0]                awaddr;
	logic                                           wvalid;
	logic                                           wready;
	logic [conv_pkg::axi_data_w-1:0]                wdata;
	logic                                           bvalid;
	logic [1:0]                                     bresp;
	logic                                           bready;
	logic                                           arvalid;
	logic                                           arready;
	logic [conv_pkg::axi_addr_w-1:0]                araddr;
	logic                                           rvalid;
	logic [conv_pkg::axi_data_w-1:0]                rdata;
	logic [1:0]                                     rresp;
	logic                                           rready;
	logic                                           pix_valid;
	logic                                           pix_sof;
	logic [conv_pkg::pix_w-1:0]                     pix_data;
	logic [conv_pkg::num_units-1:0]                 res_valid;
	logic [conv_pkg::num_units*conv_pkg::acc_w-1:0] res_data;
	int                                             results = 0;

	tb_clock_gen u_clk (.clk(clk), .rst_n(rst_n));

	conv_layer_top dut (.*);

	initial begin
		awvalid   <= 1'b0;
		awaddr    <= '0;
		wvalid    <= 1'b0;
		wdata     <= '0;
		bready    <= 1'b0;
		arvalid   <= 1'b0;
		araddr    <= '0;
		rready    <= 1'b0;
		pix_valid <= 1'b0;
		pix_sof   <= 1'b0;
		pix_data  <= '0;
	end

	always @(posedge clk) begin
		if (rst_n && res_valid[0])
			results <= results + 1;
		if (dut.chk.errors != 0) begin
			$display("sim failed");
			$fatal(1, "checker assertion fired");
		end
	end

	task automatic timeout_fail(input string what);
		$display("timeout while waiting for %s", what);
		$display("sim failed");
		$fatal(1, "wait limit exceeded");
	endtask

	function automatic logic [11:0] weight_addr(input int unit, input int tap);
		return 12'((unit << 10) | (tap << 2));
	endfunction

	function automatic logic [11:0] bias_addr(input int unit);
		return 12'(32'h800 | (unit << 10));
	endfunction

	// AW and W in random order, then B
	task automatic axi_write(input logic [11:0] addr, input logic [31:0] data);
		int  mode;
		int  n;
		bit  aw_done;
		bit  w_done;
		mode    = $urandom_range(2);
		aw_done = 1'b0;
		w_done  = 1'b0;
		n       = 0;
		@(posedge clk);
		awaddr  <= addr;
		wdata   <= data;
		awvalid <= (mode != 2);
		wvalid  <= (mode != 1);
		while (!(aw_done && w_done)) begin
			@(posedge clk);
			if (awvalid && awready) begin
				aw_done = 1'b1;
				awvalid <= 1'b0;
			end
			if (wvalid && wready) begin
				w_done = 1'b1;
				wvalid <= 1'b0;
			end
			if (aw_done && !w_done && !wvalid)
				wvalid <= 1'b1;
			if (w_done && !aw_done && !awvalid)
				awvalid <= 1'b1;
			if (++n > wait_limit)
				timeout_fail("awready/wready");
		end
		bready <= 1'b1;
		n = 0;
		do begin
			@(posedge clk);
			if (++n > wait_limit)
				timeout_fail("bvalid");
		end while (!bvalid);
		bready <= 1'b0;
	endtask

	task automatic axi_read(input logic [11:0] addr);
		int n;
		n = 0;
		@(posedge clk);
		araddr  <= addr;
		arvalid <= 1'b1;
		do begin
			@(posedge clk);
			if (++n > wait_limit)
				timeout_fail("arready");
		end while (!arready);
		arvalid <= 1'b0;
		rready  <= 1'b1;
		n = 0;
		do begin
			@(posedge clk);
			if (++n > wait_limit)
				timeout_fail("rvalid");
		end while (!rvalid);
		rready <= 1'b0;
	endtask

	// constant image with random idle gaps
	task automatic send_image(input logic [7:0] c);
		for (int i = 0; i < conv_pkg::img_w * conv_pkg::img_h; i++) begin
			if ($urandom_range(3) == 0) begin
				repeat ($urandom_range(1, 3)) begin
					@(posedge clk);
					pix_valid <= 1'b0;
					pix_sof   <= 1'b0;
				end
			end
			@(posedge clk);
			pix_valid <= 1'b1;
			pix_sof   <= (i == 0);
			pix_data  <= c;
		end
		@(posedge clk);
		pix_valid <= 1'b0;
		pix_sof   <= 1'b0;
	endtask

	initial begin
		int n;
		void'($urandom(32'he0b4));
		n = 0;
		while (rst_n !== 1'b1) begin
			@(posedge clk);
			if (++n > wait_limit)
				timeout_fail("reset release");
		end

		// unit 0 mixed signs, unit 1 all negative
		for (int t = 0; t < conv_pkg::num_taps; t++) begin
			axi_write(weight_addr(0, t), 32'(int'($urandom_range(16)) - 8));
			axi_write(weight_addr(1, t), 32'(-int'($urandom_range(1, 8))));
		end
		axi_write(bias_addr(0), 32'(int'($urandom_range(600)) - 300));
		axi_write(bias_addr(1), 32'(-int'($urandom_range(1, 100))));

		axi_write(weight_addr(0, 9), 32'h0000_7fff);  // out of range tap
		axi_write(weight_addr(1, 15), 32'h0000_1234);
		axi_read(weight_addr(0, 0));
		axi_read(12'hffc);

		for (int img = 0; img < num_images; img++)
			send_image(8'($urandom_range(255)));

		n = 0;
		while (results < 36 * num_images) begin
			@(posedge clk);
			if (++n > 200)
				timeout_fail("result drain");
		end
		repeat (4) @(posedge clk);

		if (dut.chk.errors == 0) begin
			$display("sim passed");
			$finish;
		end else begin
			$display("sim failed");
			$fatal(1, "checker errors at end of run");
		end
	end

endmodule

//--- conv_layer_checker.sv
module conv_layer_checker (
	input logic                                           clk,
	input logic                                           rst_n,
	input logic                                           awvalid,
	input logic                                           awready,
	input logic [conv_pkg::axi_addr_w-1:0]                awaddr,
	input logic                                           wvalid,
	input logic                                           wready,
	input logic [conv_pkg::axi_data_w-1:0]                wdata,
	input logic                                           bvalid,
	input logic [1:0]                                     bresp,
	input logic                                           bready,
	input logic                                           arvalid,
	input logic                                           arready,
	input logic                                           rvalid,
	input logic [conv_pkg::axi_data_w-1:0]                rdata,
	input logic [1:0]                                     rresp,
	input logic                                           pix_valid,
	input logic                                           pix_sof,
	input logic [conv_pkg::pix_w-1:0]                     pix_data,
	input logic [conv_pkg::num_units-1:0]                 res_valid,
	input logic [conv_pkg::num_units*conv_pkg::acc_w-1:0] res_data
);
	timeunit 1ns;
	timeprecision 1ps;

	int errors = 0;

	logic [conv_pkg::word_addr_w-1:0] held_word; // word index of pending write
	logic [conv_pkg::coef_w-1:0]      held_data;
	logic                             legal;
	logic signed [conv_pkg::coef_w-1:0] sh_w [conv_pkg::num_units][conv_pkg::num_taps];
	logic signed [conv_pkg::coef_w-1:0] sh_b [conv_pkg::num_units];

	int                         col;
	int                         row;
	int                         pos_col;
	int                         pos_row;
	logic                       exp_win;
	logic [conv_pkg::pix_w-1:0] img_c;
	logic [conv_pkg::pix_w-1:0] cur_c;
	logic [2:0]                 win_q; // window flag, one bit per stage
	int exp_val [conv_pkg::num_units];
	int exp_p1  [conv_pkg::num_units];
	int exp_p2  [conv_pkg::num_units];
	int exp_p3  [conv_pkg::num_units];

	// region bit 9, unit bit 8, tap in bits 3:0
	assign legal = held_word[9] || (held_word[3:0] < conv_pkg::num_taps);

	always_ff @(posedge clk) begin
		if (awvalid && awready)
			held_word <= awaddr[conv_pkg::axi_addr_w-1:2];
		if (wvalid && wready)
			held_data <= wdata[conv_pkg::coef_w-1:0];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sh_w <= '{default: '0};
			sh_b <= '{default: '0};
		end else if (bvalid && bready && legal) begin
			if (held_word[9])
				sh_b[held_word[8]] <= held_data;
			else
				sh_w[held_word[8]][held_word[3:0]] <= held_data;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// raster position and expected results
	assign pos_col = pix_sof ? 0 : col;
	assign pos_row = pix_sof ? 0 : row;
	assign cur_c   = pix_sof ? pix_data : img_c;
	assign exp_win = pix_valid && (pos_col >= conv_pkg::ksize - 1)
		&& (pos_row >= conv_pkg::ksize - 1);

	always_comb begin
		int acc;
		int val;
		for (int u = 0; u < conv_pkg::num_units; u++) begin
			acc = 0;
			for (int t = 0; t < conv_pkg::num_taps; t++)
				acc = acc + int'(sh_w[u][t]);
			val = int'(cur_c) * acc + int'(sh_b[u]);
			exp_val[u] = (val < 0) ? 0 : val; // relu
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			col   <= 0;
			row   <= 0;
			img_c <= '0;
			win_q <= '0;
		end else begin
			win_q <= {win_q[1:0], exp_win};
			if (pix_valid) begin
				img_c <= cur_c;
				col   <= (pos_col == conv_pkg::img_w - 1) ? 0 : pos_col + 1;
				if (pos_col == conv_pkg::img_w - 1)
					row <= (pos_row == conv_pkg::img_h - 1) ? 0 : pos_row + 1;
				else
					row <= pos_row;
			end
		end
	end

	always_ff @(posedge clk) begin
		exp_p1 <= exp_val;
		exp_p2 <= exp_p1;
		exp_p3 <= exp_p2;
	end

	////////////////////////////////////////////////////////////////////////////
	// assertions
	a_reset: assert property (@(posedge clk) $rose(rst_n) |->
		awready && wready && arready && !bvalid && !rvalid && (res_valid == '0))
		else begin
			$error(
				"FAILED %0t {awready,wready,arready,bvalid,rvalid,res_valid} exp=%b got=%b",
				$time, {3'b111, 2'b00, {conv_pkg::num_units{1'b0}}},
				{awready, wready, arready, bvalid, rvalid, res_valid});
			errors++;
		end

	a_bresp: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(bvalid) |-> bresp == (legal ? conv_pkg::resp_okay : conv_pkg::resp_slverr))
		else begin
			$error("FAILED %0t bresp exp=%0h got=%0h", $time,
				legal ? conv_pkg::resp_okay : conv_pkg::resp_slverr, bresp);
			errors++;
		end

	a_rresp: assert property (@(posedge clk) disable iff (!rst_n)
		rvalid |-> (rresp == conv_pkg::resp_slverr) && (rdata == '0))
		else begin
			$error("FAILED %0t rresp/rdata exp=%0h/0 got=%0h/%0h", $time,
				conv_pkg::resp_slverr, rresp, rdata);
			errors++;
		end

	a_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
		arvalid && arready |=> rvalid)
		else begin
			$error("FAILED %0t rvalid exp=1 got=%b", $time, rvalid);
			errors++;
		end

	a_res_valid: assert property (@(posedge clk) disable iff (!rst_n)
		res_valid == {conv_pkg::num_units{win_q[2]}})
		else begin
			$error("FAILED %0t res_valid exp=%b got=%b", $time,
				{conv_pkg::num_units{win_q[2]}}, res_valid);
			errors++;
		end

	for (genvar u = 0; u < conv_pkg::num_units; u++) begin : g_res
		a_res_data: assert property (@(posedge clk) disable iff (!rst_n)
			res_valid[u] |-> $signed(res_data[u*conv_pkg::acc_w +: conv_pkg::acc_w]) == exp_p3[u])
			else begin
				$error("FAILED %0t res_data[%0d] exp=%0d got=%0d", $time, u, exp_p3[u],
					$signed(res_data[u*conv_pkg::acc_w +: conv_pkg::acc_w]));
				errors++;
			end
	end

endmodule

bind conv_layer_top conv_layer_checker chk (.*);

//--- tb_clock_gen.sv
module tb_clock_gen (
	output logic clk,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period
	end

	initial begin
		rst_n = 1'b0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

//--- conv_layer_top.sv
module conv_layer_top (
	input  logic                                     clk,
	input  logic                                     rst_n,
	// host port
	input  logic                                     awvalid,
	output logic                                     awready,
	input  logic [conv_pkg::axi_addr_w-1:0]          awaddr,
	input  logic                                     wvalid,
	output logic                                     wready,
	input  logic [conv_pkg::axi_data_w-1:0]          wdata,
	output logic                                     bvalid,
	output logic [1:0]                               bresp,
	input  logic                                     bready,
	input  logic                                     arvalid,
	output logic                                     arready,
	input  logic [conv_pkg::axi_addr_w-1:0]          araddr,
	output logic                                     rvalid,
	output logic [conv_pkg::axi_data_w-1:0]          rdata,
	output logic [1:0]                               rresp,
	input  logic                                     rready,
	// pixel stream
	input  logic                                     pix_valid,
	input  logic                                     pix_sof,
	input  logic [conv_pkg::pix_w-1:0]               pix_data,
	// results, one word per unit
	output logic [conv_pkg::num_units-1:0]           res_valid,
	output logic [conv_pkg::num_units*conv_pkg::acc_w-1:0] res_data
);

	logic [conv_pkg::num_units-1:0]                  coef_we;
	logic                                            coef_bias_sel;
	logic [conv_pkg::tap_w-1:0]                      coef_tap;
	logic [conv_pkg::coef_w-1:0]                     coef_data;
	logic                                            win_valid;
	logic [conv_pkg::num_taps*conv_pkg::pix_w-1:0]   win_taps;

	axil_coef_port u_coef_port (
		.clk(clk), .rst_n(rst_n),
		.awvalid(awvalid), .awready(awready), .awaddr(awaddr),
		.wvalid(wvalid), .wready(wready), .wdata(wdata),
		.bvalid(bvalid), .bresp(bresp), .bready(bready),
		.arvalid(arvalid), .arready(arready), .araddr(araddr),
		.rvalid(rvalid), .rdata(rdata), .rresp(rresp), .rready(rready),
		.coef_we(coef_we), .coef_bias_sel(coef_bias_sel),
		.coef_tap(coef_tap), .coef_data(coef_data)
	);

	window_buffer u_window (
		.clk(clk), .rst_n(rst_n),
		.pix_valid(pix_valid), .pix_sof(pix_sof), .pix_data(pix_data),
		.win_valid(win_valid), .win_taps(win_taps)
	);

	for (genvar g = 0; g < conv_pkg::num_units; g++) begin : g_unit
		conv_unit #(.unit_id(g)) u_unit (
			.clk(clk), .rst_n(rst_n),
			.coef_we(coef_we[g]), // own strobe only
			.coef_bias_sel(coef_bias_sel),
			.coef_tap(coef_tap),
			.coef_data(coef_data),
			.win_valid(win_valid),
			.win_taps(win_taps),
			.res_valid(res_valid[g]),
			.res_data(res_data[g*conv_pkg::acc_w +: conv_pkg::acc_w])
		);
	end

endmodule

//--- conv_unit.sv
module conv_unit #(
	parameter int unit_id = 0
) (
	input  logic                                         clk,
	input  logic                                         rst_n,
	input  logic                                         coef_we,
	input  logic                                         coef_bias_sel,
	input  logic [conv_pkg::tap_w-1:0]                   coef_tap,
	input  logic [conv_pkg::coef_w-1:0]                  coef_data,
	input  logic                                         win_valid,
	input  logic [conv_pkg::num_taps*conv_pkg::pix_w-1:0] win_taps,
	output logic                                         res_valid,
	output logic [conv_pkg::acc_w-1:0]                   res_data
);

	logic signed [conv_pkg::coef_w-1:0] weight [conv_pkg::num_taps];
	logic signed [conv_pkg::coef_w-1:0] bias;
	logic signed [conv_pkg::prod_w-1:0] prod   [conv_pkg::num_taps];
	logic signed [conv_pkg::acc_w-1:0]  sum_c;
	logic signed [conv_pkg::acc_w-1:0]  sum_q;
	logic signed [conv_pkg::acc_w-1:0]  relu_q;
	logic                               v1;
	logic                               v2;
	logic                               v3;

	if (unit_id < 0 || unit_id >= conv_pkg::num_units) begin : g_bad_id
		$error("conv_unit: unit_id %0d outside 0..%0d", unit_id, conv_pkg::num_units - 1);
	end

	////////////////////////////////////////////////////////////////////////////
	// coefficient store
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int t = 0; t < conv_pkg::num_taps; t++)
				weight[t] <= '0;
			bias <= '0;
		end else if (coef_we) begin
			if (coef_bias_sel) begin
				bias <= coef_data;
			end else begin
				for (int t = 0; t < conv_pkg::num_taps; t++) begin
					if (coef_tap == conv_pkg::tap_w'(t))
						weight[t] <= coef_data;
				end
			end
		end
	end

	always_comb begin
		sum_c = bias; // sign-extended
		for (int t = 0; t < conv_pkg::num_taps; t++)
			sum_c = sum_c + prod[t];
	end

	////////////////////////////////////////////////////////////////////////////
	// multiply, sum, relu
	always_ff @(posedge clk) begin
		if (win_valid) begin
			for (int t = 0; t < conv_pkg::num_taps; t++) begin
				prod[t] <= $signed({1'b0, win_taps[t*conv_pkg::pix_w +: conv_pkg::pix_w]})
					* weight[t];
			end
		end
		if (v1)
			sum_q <= sum_c;
		if (v2)
			relu_q <= sum_q[conv_pkg::acc_w-1] ? '0 : sum_q; // clamp negatives
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			v1 <= 1'b0;
			v2 <= 1'b0;
			v3 <= 1'b0;
		end else begin
			v1 <= win_valid;
			v2 <= v1;
			v3 <= v2;
		end
	end

	assign res_valid = v3;
	assign res_data  = relu_q;

endmodule

//--- window_buffer.sv
module window_buffer (
	input  logic                                         clk,
	input  logic                                         rst_n,
	input  logic                                         pix_valid,
	input  logic                                         pix_sof,
	input  logic [conv_pkg::pix_w-1:0]                   pix_data,
	output logic                                         win_valid,
	output logic [conv_pkg::num_taps*conv_pkg::pix_w-1:0] win_taps
);

	logic [conv_pkg::col_w-1:0] col;     // next expected position
	logic [conv_pkg::row_w-1:0] row;
	logic [conv_pkg::col_w-1:0] cur_col; // position of pix_data
	logic [conv_pkg::row_w-1:0] cur_row;

	logic [conv_pkg::pix_w-1:0] line_a [conv_pkg::img_w]; // row above
	logic [conv_pkg::pix_w-1:0] line_b [conv_pkg::img_w]; // two rows above
	logic [conv_pkg::pix_w-1:0] now_px [conv_pkg::ksize]; // current column, top first
	logic [conv_pkg::pix_w-1:0] sh1    [conv_pkg::ksize]; // one column left
	logic [conv_pkg::pix_w-1:0] sh2    [conv_pkg::ksize]; // two columns left

	assign cur_col = pix_sof ? '0 : col;
	assign cur_row = pix_sof ? '0 : row;

	assign now_px[0] = line_b[cur_col];
	assign now_px[1] = line_a[cur_col];
	assign now_px[2] = pix_data;

	assign win_valid = pix_valid
		&& (cur_col >= conv_pkg::col_w'(conv_pkg::ksize - 1))
		&& (cur_row >= conv_pkg::row_w'(conv_pkg::ksize - 1));

	// tap index is row*ksize + column, oldest first
	always_comb begin
		for (int ky = 0; ky < conv_pkg::ksize; ky++) begin
			win_taps[(ky*conv_pkg::ksize + 0)*conv_pkg::pix_w +: conv_pkg::pix_w] = sh2[ky];
			win_taps[(ky*conv_pkg::ksize + 1)*conv_pkg::pix_w +: conv_pkg::pix_w] = sh1[ky];
			win_taps[(ky*conv_pkg::ksize + 2)*conv_pkg::pix_w +: conv_pkg::pix_w] = now_px[ky];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// raster position
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			col <= '0;
			row <= '0;
		end else if (pix_valid) begin
			if (cur_col == conv_pkg::col_w'(conv_pkg::img_w - 1)) begin
				col <= '0;
				if (cur_row == conv_pkg::row_w'(conv_pkg::img_h - 1))
					row <= '0;
				else
					row <= cur_row + 1'b1;
			end else begin
				col <= cur_col + 1'b1;
				row <= cur_row;
			end
		end
	end

	// line buffers and window columns
	always_ff @(posedge clk) begin
		if (pix_valid) begin
			line_b[cur_col] <= line_a[cur_col];
			line_a[cur_col] <= pix_data;
			for (int k = 0; k < conv_pkg::ksize; k++) begin
				sh2[k] <= sh1[k];
				sh1[k] <= now_px[k];
			end
		end
	end

endmodule

//--- axil_coef_port.sv
module axil_coef_port (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              awvalid,
	output logic                              awready,
	input  logic [conv_pkg::axi_addr_w-1:0]   awaddr,
	input  logic                              wvalid,
	output logic                              wready,
	input  logic [conv_pkg::axi_data_w-1:0]   wdata,
	output logic                              bvalid,
	output logic [1:0]                        bresp,
	input  logic                              bready,
	input  logic                              arvalid,
	output logic                              arready,
	input  logic [conv_pkg::axi_addr_w-1:0]   araddr,
	output logic                              rvalid,
	output logic [conv_pkg::axi_data_w-1:0]   rdata,
	output logic [1:0]                        rresp,
	input  logic                              rready,
	output logic [conv_pkg::num_units-1:0]    coef_we,
	output logic                              coef_bias_sel,
	output logic [conv_pkg::tap_w-1:0]        coef_tap,
	output logic [conv_pkg::coef_w-1:0]       coef_data
);

	conv_pkg::coef_addr_u          aw_word;  // held word index
	logic [conv_pkg::coef_w-1:0]   w_coef;   // held coefficient
	logic                          aw_held;
	logic                          w_held;
	logic                          wr_fire;
	logic                          addr_ok;
	logic                          unit_sel;

	assign awready = !aw_held; // low until B is taken
	assign wready  = !w_held;
	assign arready = !rvalid;
	assign wr_fire = aw_held && w_held && !bvalid;

	////////////////////////////////////////////////////////////////////////////
	// address decode, view chosen by the region bit
	always_comb begin
		unit_sel = aw_word.weight.unit; // same position in both views
		if (aw_word.bias.region) begin
			addr_ok = 1'b1;
		end else begin
			addr_ok = aw_word.weight.tap < conv_pkg::tap_w'(conv_pkg::num_taps);
		end
	end

	assign coef_bias_sel = aw_word.bias.region;
	assign coef_tap      = aw_word.weight.tap;
	assign coef_data     = w_coef;

	// channel payloads, stable while the response is pending
	always_ff @(posedge clk) begin
		if (awvalid && awready)
			aw_word <= awaddr[conv_pkg::axi_addr_w-1:2];
		if (wvalid && wready)
			w_coef <= wdata[conv_pkg::coef_w-1:0];
	end

	////////////////////////////////////////////////////////////////////////////
	// write channel state
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			aw_held <= 1'b0;
			w_held  <= 1'b0;
			bvalid  <= 1'b0;
			bresp   <= conv_pkg::resp_okay;
			coef_we <= '0;
		end else begin
			coef_we <= '0; // single-cycle strobe
			if (awvalid && awready)
				aw_held <= 1'b1;
			if (wvalid && wready)
				w_held <= 1'b1;
			if (wr_fire) begin
				bvalid <= 1'b1;
				bresp  <= addr_ok ? conv_pkg::resp_okay : conv_pkg::resp_slverr;
				for (int i = 0; i < conv_pkg::num_units; i++) begin
					coef_we[i] <= addr_ok && (unit_sel == 1'(i));
				end
			end else if (bvalid && bready) begin
				bvalid  <= 1'b0;
				aw_held <= 1'b0;
				w_held  <= 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// read channel, nothing is readable
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rvalid <= 1'b0;
		end else if (arvalid && arready) begin
			rvalid <= 1'b1;
		end else if (rvalid && rready) begin
			rvalid <= 1'b0;
		end
	end

	assign rdata = '0;
	assign rresp = conv_pkg::resp_slverr;

endmodule

//--- conv_pkg.sv
package conv_pkg;

	////////////////////////////////////////////////////////////////////////////
	// layer geometry
	localparam int img_w     = 8;
	localparam int img_h     = 8;
	localparam int ksize     = 3;
	localparam int num_taps  = 9;
	localparam int num_units = 2;

	// data widths
	localparam int pix_w  = 8;                  // unsigned pixel
	localparam int coef_w = 16;                 // signed weight / bias
	localparam int acc_w  = 32;                 // signed result
	localparam int prod_w = pix_w + 1 + coef_w; // zero-extended pixel times weight

	// counters and host addressing
	localparam int col_w       = 3;
	localparam int row_w       = 3;
	localparam int tap_w       = 4;
	localparam int axi_addr_w  = 12;
	localparam int axi_data_w  = 32;
	localparam int word_addr_w = axi_addr_w - 2; // byte address minus low two bits

	localparam logic [1:0] resp_okay   = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	////////////////////////////////////////////////////////////////////////////
	// coefficient word index, top bit picks weight or bias region
	typedef struct packed {
		logic             region; // 0
		logic             unit;
		logic [3:0]       pad;
		logic [tap_w-1:0] tap;
	} coef_weight_t;

	typedef struct packed {
		logic       region; // 1
		logic       unit;
		logic [7:0] pad;
	} coef_bias_t;

	typedef union packed {
		coef_weight_t weight;
		coef_bias_t   bias;
	} coef_addr_u;

endpackage
